// File: verilog/vout_timing_pkg.sv
package vout_timing_pkg;

	// counter widths for the default build
	localparam int H_WIDTH_DEF = 12;
	localparam int V_WIDTH_DEF = 12;

	// width of every timing register field
	localparam int TIMING_W = 12;

	typedef struct packed {
		logic [TIMING_W-1:0] htotal;
		logic [TIMING_W-1:0] hdisp_start;
		logic [TIMING_W-1:0] hdisp_end;
		logic [TIMING_W-1:0] hsync_start;
		logic [TIMING_W-1:0] hsync_end;
		logic [TIMING_W-1:0] vtotal;
		logic [TIMING_W-1:0] vdisp_start;
		logic [TIMING_W-1:0] vdisp_end;
		logic [TIMING_W-1:0] vsync_start;
		logic [TIMING_W-1:0] vsync_end;
		logic                hsync_pol;
		logic                vsync_pol;
	} vout_timing_t;

	// 640x480, sync pulse at the start of line and frame
	localparam vout_timing_t TIMING_DEFAULT = '{
		htotal:      12'd800,
		hdisp_start: 12'd112,
		hdisp_end:   12'd752,
		hsync_start: 12'd0,
		hsync_end:   12'd96,
		vtotal:      12'd525,
		vdisp_start: 12'd12,
		vdisp_end:   12'd492,
		vsync_start: 12'd0,
		vsync_end:   12'd2,
		hsync_pol:   1'b0,
		vsync_pol:   1'b0
	};

	// raw syncs are active high here
	typedef struct packed {
		logic                de;
		logic                hsync;
		logic                vsync;
		logic [TIMING_W-1:0] x;
		logic [TIMING_W-1:0] y;
	} vout_raw_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} frame_state_e;

	typedef enum logic {
		PAT_RAMP  = 1'b0,
		PAT_SOLID = 1'b1
	} pattern_mode_e;

endpackage

// File: verilog/vout_bus_pkg.sv
package vout_bus_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	// word index, byte address is index * 4
	typedef enum logic [5:0] {
		REG_CTRL        = 6'd0,
		REG_STATUS      = 6'd1,
		REG_HTOTAL      = 6'd2,
		REG_HDISP_START = 6'd3,
		REG_HDISP_END   = 6'd4,
		REG_HSYNC_START = 6'd5,
		REG_HSYNC_END   = 6'd6,
		REG_VTOTAL      = 6'd7,
		REG_VDISP_START = 6'd8,
		REG_VDISP_END   = 6'd9,
		REG_VSYNC_START = 6'd10,
		REG_VSYNC_END   = 6'd11,
		REG_POLARITY    = 6'd12,
		REG_PATTERN     = 6'd13,
		REG_COLOR       = 6'd14
	} reg_index_e;

endpackage

// File: verilog/vout_apb_regs.sv
`timescale 1ns/10ps

module vout_apb_regs (
	input  logic                          peri_aclk,
	input  logic                          peri_aresetn,
	input  vout_bus_pkg::apb_req_t        apb_req_i,
	output vout_bus_pkg::apb_rsp_t        apb_rsp_o,
	input  vout_timing_pkg::frame_state_e state_i,
	input  logic                          frame_active_i,
	output logic                          enable_o,
	output vout_timing_pkg::vout_timing_t timing_o,
	output vout_timing_pkg::pattern_mode_e mode_o,
	output logic [23:0]                   color_o
);
	import vout_bus_pkg::*;
	import vout_timing_pkg::*;

	logic          enable_q;
	vout_timing_t  timing_q;
	pattern_mode_e mode_q;
	logic [23:0]   color_q;

	logic          access;
	logic          addr_bad;
	reg_index_e    reg_idx;
	logic [31:0]   rdata;
	logic [TIMING_W-1:0] wfield;

	// ------------------------------------------------
	// address decode
	// ------------------------------------------------

	assign access   = apb_req_i.psel && apb_req_i.penable;
	assign reg_idx  = reg_index_e'(apb_req_i.paddr[7:2]);
	// unaligned or past the last register
	assign addr_bad = (apb_req_i.paddr[1:0] != 2'b00) ||
		(apb_req_i.paddr[7:2] > 6'(REG_COLOR));
	assign wfield   = apb_req_i.pwdata[TIMING_W-1:0];

	// ------------------------------------------------
	// register writes
	// ------------------------------------------------

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			enable_q <= 1'b0;
			timing_q <= TIMING_DEFAULT;
			mode_q   <= PAT_RAMP;
			color_q  <= 24'd0;
		end else if (access && apb_req_i.pwrite && !addr_bad) begin
			case (reg_idx)
				REG_CTRL:        enable_q <= apb_req_i.pwdata[0];
				REG_HTOTAL:      timing_q.htotal <= wfield;
				REG_HDISP_START: timing_q.hdisp_start <= wfield;
				REG_HDISP_END:   timing_q.hdisp_end <= wfield;
				REG_HSYNC_START: timing_q.hsync_start <= wfield;
				REG_HSYNC_END:   timing_q.hsync_end <= wfield;
				REG_VTOTAL:      timing_q.vtotal <= wfield;
				REG_VDISP_START: timing_q.vdisp_start <= wfield;
				REG_VDISP_END:   timing_q.vdisp_end <= wfield;
				REG_VSYNC_START: timing_q.vsync_start <= wfield;
				REG_VSYNC_END:   timing_q.vsync_end <= wfield;
				REG_POLARITY: begin
					timing_q.hsync_pol <= apb_req_i.pwdata[0];
					timing_q.vsync_pol <= apb_req_i.pwdata[1];
				end
				REG_PATTERN:     mode_q <= pattern_mode_e'(apb_req_i.pwdata[0]);
				REG_COLOR:       color_q <= apb_req_i.pwdata[23:0];
				// status is read only
				default: ;
			endcase
		end
	end

	// ------------------------------------------------
	// read mux
	// ------------------------------------------------

	always_comb begin
		rdata = 32'd0;
		case (reg_idx)
			REG_CTRL:        rdata[0] = enable_q;
			REG_STATUS:      rdata[1:0] = {frame_active_i, state_i != IDLE};
			REG_HTOTAL:      rdata[TIMING_W-1:0] = timing_q.htotal;
			REG_HDISP_START: rdata[TIMING_W-1:0] = timing_q.hdisp_start;
			REG_HDISP_END:   rdata[TIMING_W-1:0] = timing_q.hdisp_end;
			REG_HSYNC_START: rdata[TIMING_W-1:0] = timing_q.hsync_start;
			REG_HSYNC_END:   rdata[TIMING_W-1:0] = timing_q.hsync_end;
			REG_VTOTAL:      rdata[TIMING_W-1:0] = timing_q.vtotal;
			REG_VDISP_START: rdata[TIMING_W-1:0] = timing_q.vdisp_start;
			REG_VDISP_END:   rdata[TIMING_W-1:0] = timing_q.vdisp_end;
			REG_VSYNC_START: rdata[TIMING_W-1:0] = timing_q.vsync_start;
			REG_VSYNC_END:   rdata[TIMING_W-1:0] = timing_q.vsync_end;
			REG_POLARITY:    rdata[1:0] = {timing_q.vsync_pol, timing_q.hsync_pol};
			REG_PATTERN:     rdata[0] = mode_q;
			REG_COLOR:       rdata[23:0] = color_q;
			default:         rdata = 32'd0;
		endcase
		if (addr_bad) begin
			rdata = 32'd0;
		end
	end

	// no wait states
	assign apb_rsp_o.prdata  = rdata;
	assign apb_rsp_o.pready  = access;
	assign apb_rsp_o.pslverr = access && addr_bad;

	assign enable_o = enable_q;
	assign timing_o = timing_q;
	assign mode_o   = mode_q;
	assign color_o  = color_q;

endmodule

// File: verilog/vout_frame_fsm.sv
`timescale 1ns/10ps

module vout_frame_fsm (
	input  logic                          peri_aclk,
	input  logic                          peri_aresetn,
	input  logic                          enable_i,
	input  logic                          frame_end_i,
	output logic                          run_o,
	output logic                          load_shadow_o,
	output vout_timing_pkg::frame_state_e state_o
);
	import vout_timing_pkg::*;

	frame_state_e state_q;
	frame_state_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (enable_i) begin
					state_d = RUN;
				end
			end
			RUN: begin
				// enable dropped on the last pixel, stop right away
				if (!enable_i) begin
					state_d = frame_end_i ? IDLE : DRAIN;
				end
			end
			DRAIN: begin
				if (enable_i) begin
					state_d = RUN;
				end else if (frame_end_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// new timing at start and at every frame boundary that keeps running
	assign load_shadow_o = enable_i && ((state_q == IDLE) || frame_end_i);
	assign run_o         = (state_q != IDLE);
	assign state_o       = state_q;

endmodule

// File: verilog/vout_timing_counter.sv
`timescale 1ns/10ps

module vout_timing_counter #(
	parameter int H_WIDTH = vout_timing_pkg::H_WIDTH_DEF,
	parameter int V_WIDTH = vout_timing_pkg::V_WIDTH_DEF
) (
	input  logic                          peri_aclk,
	input  logic                          peri_aresetn,
	input  logic                          run_i,
	input  logic                          load_shadow_i,
	input  vout_timing_pkg::vout_timing_t timing_i,
	output vout_timing_pkg::vout_raw_t    raw_o,
	output logic                          frame_end_o,
	output logic                          frame_active_o
);
	import vout_timing_pkg::*;

	vout_timing_t        shadow_q;
	logic [H_WIDTH-1:0]  h_cnt;
	logic [V_WIDTH-1:0]  v_cnt;
	logic [TIMING_W-1:0] h_pos;
	logic [TIMING_W-1:0] v_pos;
	logic                h_last;
	logic                v_last;
	logic                v_disp;

	function automatic logic in_window(
		input logic [TIMING_W-1:0] pos,
		input logic [TIMING_W-1:0] lo,
		input logic [TIMING_W-1:0] hi
	);
		return (pos >= lo) && (pos < hi);
	endfunction

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			shadow_q <= TIMING_DEFAULT;
		end else if (load_shadow_i) begin
			shadow_q <= timing_i;
		end
	end

	assign h_pos  = TIMING_W'(h_cnt);
	assign v_pos  = TIMING_W'(v_cnt);
	assign h_last = (h_pos == shadow_q.htotal - TIMING_W'(1));
	assign v_last = (v_pos == shadow_q.vtotal - TIMING_W'(1));

	// ------------------------------------------------
	// counters, parked at zero while stopped
	// ------------------------------------------------

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (!run_i) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			v_cnt <= v_last ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// ------------------------------------------------
	// window decode
	// ------------------------------------------------

	assign v_disp = in_window(v_pos, shadow_q.vdisp_start, shadow_q.vdisp_end);

	assign raw_o.de    = run_i && v_disp &&
		in_window(h_pos, shadow_q.hdisp_start, shadow_q.hdisp_end);
	assign raw_o.hsync = run_i && in_window(h_pos, shadow_q.hsync_start, shadow_q.hsync_end);
	assign raw_o.vsync = run_i && in_window(v_pos, shadow_q.vsync_start, shadow_q.vsync_end);
	assign raw_o.x     = h_pos - shadow_q.hdisp_start;
	assign raw_o.y     = v_pos - shadow_q.vdisp_start;

	assign frame_end_o    = run_i && h_last && v_last;
	assign frame_active_o = run_i && v_disp;

endmodule

// File: verilog/vout_pixel_gen.sv
`timescale 1ns/10ps

module vout_pixel_gen #(
	parameter int H_WIDTH = vout_timing_pkg::H_WIDTH_DEF,
	parameter int V_WIDTH = vout_timing_pkg::V_WIDTH_DEF
) (
	input  logic                           peri_aclk,
	input  logic                           peri_aresetn,
	input  vout_timing_pkg::vout_raw_t     raw_i,
	input  vout_timing_pkg::pattern_mode_e mode_i,
	input  logic [23:0]                    color_i,
	input  logic                           hsync_pol_i,
	input  logic                           vsync_pol_i,
	output logic                           vga_hsync_o,
	output logic                           vga_vsync_o,
	output logic                           vga_de_o,
	output logic [4:0]                     vga_r_o,
	output logic [5:0]                     vga_g_o,
	output logic [4:0]                     vga_b_o
);
	import vout_timing_pkg::*;

	logic [H_WIDTH-1:0] px_x;
	logic [V_WIDTH-1:0] px_y;
	logic [7:0]         ramp_b;
	logic [23:0]        pixel;

	assign px_x   = H_WIDTH'(raw_i.x);
	assign px_y   = V_WIDTH'(raw_i.y);
	assign ramp_b = px_x[7:0] + px_y[7:0];

	always_comb begin
		if (!raw_i.de) begin
			pixel = 24'd0;
		end else if (mode_i == PAT_SOLID) begin
			pixel = color_i;
		end else begin
			pixel = {px_x[7:0], px_y[7:0], ramp_b};
		end
	end

	// output stage, 5-6-5 from the top bits of each channel
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			vga_hsync_o <= ~hsync_pol_i;
			vga_vsync_o <= ~vsync_pol_i;
			vga_de_o    <= 1'b0;
			vga_r_o     <= 5'd0;
			vga_g_o     <= 6'd0;
			vga_b_o     <= 5'd0;
		end else begin
			// pol 1 passes the raw sync, pol 0 inverts it
			vga_hsync_o <= ~(raw_i.hsync ^ hsync_pol_i);
			vga_vsync_o <= ~(raw_i.vsync ^ vsync_pol_i);
			vga_de_o    <= raw_i.de;
			vga_r_o     <= pixel[23:19];
			vga_g_o     <= pixel[15:10];
			vga_b_o     <= pixel[7:3];
		end
	end

endmodule

// File: verilog/vout_top.sv
`timescale 1ns/10ps

module vout_top #(
	parameter int H_WIDTH = vout_timing_pkg::H_WIDTH_DEF,
	parameter int V_WIDTH = vout_timing_pkg::V_WIDTH_DEF
) (
	input  logic                   peri_aclk,
	input  logic                   peri_aresetn,
	input  vout_bus_pkg::apb_req_t apb_req_i,
	output vout_bus_pkg::apb_rsp_t apb_rsp_o,
	output logic                   vga_hsync_o,
	output logic                   vga_vsync_o,
	output logic                   vga_de_o,
	output logic [4:0]             vga_r_o,
	output logic [5:0]             vga_g_o,
	output logic [4:0]             vga_b_o
);
	import vout_timing_pkg::*;

	logic          enable;
	vout_timing_t  timing;
	pattern_mode_e mode;
	logic [23:0]   color;
	logic          run;
	logic          load_shadow;
	frame_state_e  state;
	logic          frame_end;
	logic          frame_active;
	vout_raw_t     raw;

	vout_apb_regs u_regs (
		.peri_aclk      (peri_aclk),
		.peri_aresetn   (peri_aresetn),
		.apb_req_i      (apb_req_i),
		.apb_rsp_o      (apb_rsp_o),
		.state_i        (state),
		.frame_active_i (frame_active),
		.enable_o       (enable),
		.timing_o       (timing),
		.mode_o         (mode),
		.color_o        (color)
	);

	vout_frame_fsm u_fsm (
		.peri_aclk     (peri_aclk),
		.peri_aresetn  (peri_aresetn),
		.enable_i      (enable),
		.frame_end_i   (frame_end),
		.run_o         (run),
		.load_shadow_o (load_shadow),
		.state_o       (state)
	);

	vout_timing_counter #(
		.H_WIDTH (H_WIDTH),
		.V_WIDTH (V_WIDTH)
	) u_counter (
		.peri_aclk      (peri_aclk),
		.peri_aresetn   (peri_aresetn),
		.run_i          (run),
		.load_shadow_i  (load_shadow),
		.timing_i       (timing),
		.raw_o          (raw),
		.frame_end_o    (frame_end),
		.frame_active_o (frame_active)
	);

	// polarity is taken live from the registers
	vout_pixel_gen #(
		.H_WIDTH (H_WIDTH),
		.V_WIDTH (V_WIDTH)
	) u_pixel (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.raw_i        (raw),
		.mode_i       (mode),
		.color_i      (color),
		.hsync_pol_i  (timing.hsync_pol),
		.vsync_pol_i  (timing.vsync_pol),
		.vga_hsync_o  (vga_hsync_o),
		.vga_vsync_o  (vga_vsync_o),
		.vga_de_o     (vga_de_o),
		.vga_r_o      (vga_r_o),
		.vga_g_o      (vga_g_o),
		.vga_b_o      (vga_b_o)
	);

endmodule

// File: sim/vout_assertions.sv
`timescale 1ns/10ps

module vout_assertions (
	input logic                   peri_aclk,
	input logic                   peri_aresetn,
	input vout_bus_pkg::apb_req_t apb_req_i,
	input logic                   vga_hsync_o,
	input logic                   vga_vsync_o,
	input logic                   vga_de_o,
	input logic [4:0]             vga_r_o,
	input logic [5:0]             vga_g_o,
	input logic [4:0]             vga_b_o
);
	import vout_bus_pkg::*;
	import vout_timing_pkg::*;

	vout_timing_t  cfg;
	vout_timing_t  frame_cfg;
	vout_timing_t  cur_cfg;
	pattern_mode_e mode;
	pattern_mode_e mode_d;
	logic [23:0]   color;
	logic [23:0]   color_d;
	logic          hpol_d;
	logic          vpol_d;
	logic          wr_access;
	logic          en_cfg;
	logic [2:0]    en_pipe;

	logic          hs_act;
	logic          vs_act;
	logic          hs_prev;
	logic          vs_prev;
	logic          de_prev;
	logic          hs_rise;
	logic          hs_fall;
	logic          vs_rise;
	logic          de_fall;

	logic [11:0]   h_cnt;
	logic [11:0]   line_ht;
	logic          h_seen;
	logic [11:0]   hw_cnt;
	logic [11:0]   de_cnt;
	logic [11:0]   de_lines;
	logic [23:0]   v_cnt;
	logic [23:0]   frame_len;
	logic          v_seen;
	logic [11:0]   x_cur;
	logic [7:0]    ramp_b;
	logic [23:0]   exp_px;

	// ------------------------------------------------
	// register copy from observed APB writes
	// ------------------------------------------------

	assign wr_access = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
		(apb_req_i.paddr[1:0] == 2'b00);

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			cfg    <= TIMING_DEFAULT;
			mode   <= PAT_RAMP;
			color  <= 24'd0;
			en_cfg <= 1'b0;
		end else if (wr_access) begin
			case (reg_index_e'(apb_req_i.paddr[7:2]))
				REG_CTRL:        en_cfg <= apb_req_i.pwdata[0];
				REG_HTOTAL:      cfg.htotal <= apb_req_i.pwdata[11:0];
				REG_HDISP_START: cfg.hdisp_start <= apb_req_i.pwdata[11:0];
				REG_HDISP_END:   cfg.hdisp_end <= apb_req_i.pwdata[11:0];
				REG_HSYNC_START: cfg.hsync_start <= apb_req_i.pwdata[11:0];
				REG_HSYNC_END:   cfg.hsync_end <= apb_req_i.pwdata[11:0];
				REG_VTOTAL:      cfg.vtotal <= apb_req_i.pwdata[11:0];
				REG_VDISP_START: cfg.vdisp_start <= apb_req_i.pwdata[11:0];
				REG_VDISP_END:   cfg.vdisp_end <= apb_req_i.pwdata[11:0];
				REG_VSYNC_START: cfg.vsync_start <= apb_req_i.pwdata[11:0];
				REG_VSYNC_END:   cfg.vsync_end <= apb_req_i.pwdata[11:0];
				REG_POLARITY: begin
					cfg.hsync_pol <= apb_req_i.pwdata[0];
					cfg.vsync_pol <= apb_req_i.pwdata[1];
				end
				REG_PATTERN:     mode <= pattern_mode_e'(apb_req_i.pwdata[0]);
				REG_COLOR:       color <= apb_req_i.pwdata[23:0];
				default: ;
			endcase
		end
	end

	// ------------------------------------------------
	// edge detect and line / frame counters
	// ------------------------------------------------

	// output stage sees live values one cycle late
	assign hs_act  = (vga_hsync_o == hpol_d);
	assign vs_act  = (vga_vsync_o == vpol_d);
	assign hs_rise = hs_act && !hs_prev;
	assign hs_fall = !hs_act && hs_prev;
	assign vs_rise = vs_act && !vs_prev;
	assign de_fall = !vga_de_o && de_prev;

	assign cur_cfg   = vs_rise ? cfg : frame_cfg;
	assign frame_len = 24'(frame_cfg.htotal) * 24'(frame_cfg.vtotal);
	assign x_cur     = de_prev ? de_cnt : 12'd0;
	assign ramp_b    = x_cur[7:0] + de_lines[7:0];
	assign exp_px    = (mode_d == PAT_SOLID) ? color_d : {x_cur[7:0], de_lines[7:0], ramp_b};

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			mode_d    <= PAT_RAMP;
			color_d   <= 24'd0;
			hpol_d    <= 1'b0;
			vpol_d    <= 1'b0;
			en_pipe   <= 3'd0;
			hs_prev   <= 1'b0;
			vs_prev   <= 1'b0;
			de_prev   <= 1'b0;
			h_cnt     <= 12'd0;
			line_ht   <= 12'd0;
			h_seen    <= 1'b0;
			hw_cnt    <= 12'd0;
			de_cnt    <= 12'd0;
			de_lines  <= 12'd0;
			v_cnt     <= 24'd0;
			v_seen    <= 1'b0;
			frame_cfg <= TIMING_DEFAULT;
		end else begin
			mode_d  <= mode;
			color_d <= color;
			hpol_d  <= cfg.hsync_pol;
			vpol_d  <= cfg.vsync_pol;
			// enable as the FSM saw it on the last pixel
			en_pipe <= {en_pipe[1:0], en_cfg};
			hs_prev <= hs_act;
			vs_prev <= vs_act;
			de_prev <= vga_de_o;
			if (hs_rise) begin
				h_cnt   <= 12'd1;
				h_seen  <= 1'b1;
				line_ht <= cur_cfg.htotal;
			end else begin
				if (h_cnt != 12'hfff) begin
					h_cnt <= h_cnt + 12'd1;
				end
				// line overran so output stopped
				if (h_cnt > line_ht) begin
					h_seen <= 1'b0;
				end
			end
			if (hs_act) begin
				hw_cnt <= hs_rise ? 12'd1 : hw_cnt + 12'd1;
			end
			if (vga_de_o) begin
				de_cnt <= x_cur + 12'd1;
			end
			if (vs_rise) begin
				v_cnt     <= 24'd1;
				v_seen    <= 1'b1;
				frame_cfg <= cfg;
				de_lines  <= 12'd0;
			end else begin
				if (v_cnt != 24'hffffff) begin
					v_cnt <= v_cnt + 24'd1;
				end
				if (v_cnt > frame_len) begin
					v_seen <= 1'b0;
				end
				if (de_fall) begin
					de_lines <= de_lines + 12'd1;
				end
			end
		end
	end

	// ------------------------------------------------
	// checks
	// ------------------------------------------------

	a_line_period: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		hs_rise && h_seen && (h_cnt <= line_ht) |-> h_cnt == line_ht)
		else $error("hsync period wrong");

	a_line_stop: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		h_seen && (h_cnt > line_ht) |-> !en_pipe[2] && (v_cnt == frame_len + 24'd1))
		else $error("line overran while enabled or before frame end");

	a_hsync_width: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		hs_fall |-> hw_cnt == frame_cfg.hsync_end - frame_cfg.hsync_start)
		else $error("hsync pulse width wrong");

	a_de_width: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		de_fall |-> de_cnt == frame_cfg.hdisp_end - frame_cfg.hdisp_start)
		else $error("de width per line wrong");

	a_frame_period: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		vs_rise && v_seen && (v_cnt <= frame_len) |-> v_cnt == frame_len)
		else $error("vsync period wrong");

	a_frame_stop: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		v_seen && (v_cnt > frame_len) |-> !en_pipe[2])
		else $error("frame overran while enabled");

	a_frame_lines: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		vs_rise && v_seen && (v_cnt <= frame_len) |->
		de_lines == frame_cfg.vdisp_end - frame_cfg.vdisp_start)
		else $error("de line count per frame wrong");

	a_pixel: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		vga_de_o |-> {vga_r_o, vga_g_o, vga_b_o} == {exp_px[23:19], exp_px[15:10], exp_px[7:3]})
		else $error("pixel colour wrong");

	a_blank: assert property (@(posedge peri_aclk) disable iff (!peri_aresetn)
		!vga_de_o |-> {vga_r_o, vga_g_o, vga_b_o} == 16'd0)
		else $error("colour not blank outside de");

endmodule

bind vout_top vout_assertions chk_i (
	.peri_aclk    (peri_aclk),
	.peri_aresetn (peri_aresetn),
	.apb_req_i    (apb_req_i),
	.vga_hsync_o  (vga_hsync_o),
	.vga_vsync_o  (vga_vsync_o),
	.vga_de_o     (vga_de_o),
	.vga_r_o      (vga_r_o),
	.vga_g_o      (vga_g_o),
	.vga_b_o      (vga_b_o)
);

// File: sim/vout_tb.sv
`timescale 1ns/10ps

module vout_tb;
	import vout_bus_pkg::*;
	import vout_timing_pkg::*;

	localparam int TIMEOUT = 4000;

	logic        peri_aclk;
	logic        peri_aresetn;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        vga_hsync;
	logic        vga_vsync;
	logic        vga_de;
	logic [4:0]  vga_r;
	logic [5:0]  vga_g;
	logic [4:0]  vga_b;

	logic [31:0] rng;
	logic        hpol;
	logic        vpol;
	logic [31:0] cur_ht;

	vout_top #(
		.H_WIDTH (12),
		.V_WIDTH (12)
	) dut_i (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.apb_req_i    (apb_req),
		.apb_rsp_o    (apb_rsp),
		.vga_hsync_o  (vga_hsync),
		.vga_vsync_o  (vga_vsync),
		.vga_de_o     (vga_de),
		.vga_r_o      (vga_r),
		.vga_g_o      (vga_g),
		.vga_b_o      (vga_b)
	);

	initial begin
		peri_aclk = 1'b0;
		forever #2 peri_aclk = ~peri_aclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic draw_random(output logic [31:0] val);
		rng = xorshift(rng);
		val = rng;
	endtask

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
			abort_run();
		end
	endtask

	// ------------------------------------------------
	// APB access
	// ------------------------------------------------

	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int cycles;
		cycles = 0;
		@(posedge peri_aclk);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge peri_aclk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge peri_aclk);
		while (!apb_rsp.pready) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				report_timeout("pready");
			end
			@(negedge peri_aclk);
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge peri_aclk);
		#1;
		apb_req = '0;
	endtask

	task automatic reg_write(input reg_index_e idx, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b1, {idx, 2'b00}, data, rd, err);
		check_value($sformatf("write err %s", idx.name()), 32'd0, {31'd0, err});
	endtask

	task automatic reg_read(input reg_index_e idx, output logic [31:0] data);
		logic err;
		apb_transfer(1'b0, {idx, 2'b00}, 32'd0, data, err);
		check_value($sformatf("read err %s", idx.name()), 32'd0, {31'd0, err});
	endtask

	task automatic reg_expect(input reg_index_e idx, input logic [31:0] exp);
		logic [31:0] rd;
		reg_read(idx, rd);
		check_value($sformatf("read %s", idx.name()), exp, rd);
	endtask

	task automatic expect_slverr(input logic wr, input logic [7:0] addr);
		logic [31:0] rd;
		logic        err;
		apb_transfer(wr, addr, 32'hffff_ffff, rd, err);
		check_value($sformatf("slverr addr 0x%02h", addr), 32'd1, {31'd0, err});
	endtask

	// ------------------------------------------------
	// video waits
	// ------------------------------------------------

	task automatic wait_vsync(input int n);
		int   count;
		int   cycles;
		logic prev;
		logic cur;
		count  = 0;
		cycles = 0;
		prev   = (vga_vsync == vpol);
		while (count < n) begin
			@(negedge peri_aclk);
			cur = (vga_vsync == vpol);
			if (cur && !prev) begin
				count++;
			end
			prev = cur;
			cycles++;
			if (cycles > TIMEOUT * n) begin
				report_timeout("vsync");
			end
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int          polls;
		polls = 0;
		reg_read(REG_STATUS, st);
		while (st[0]) begin
			polls++;
			if (polls > TIMEOUT) begin
				report_timeout("STATUS busy to clear");
			end
			reg_read(REG_STATUS, st);
		end
	endtask

	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge peri_aclk);
			check_value("quiet de", 32'd0, {31'd0, vga_de});
			check_value("quiet hsync", {31'd0, ~hpol}, {31'd0, vga_hsync});
			check_value("quiet vsync", {31'd0, ~vpol}, {31'd0, vga_vsync});
		end
	endtask

	// ------------------------------------------------
	// test steps
	// ------------------------------------------------

	task automatic check_registers();
		reg_expect(REG_CTRL, 32'd0);
		reg_expect(REG_STATUS, 32'd0);
		reg_expect(REG_HTOTAL, 32'd800);
		reg_expect(REG_HDISP_START, 32'd112);
		reg_expect(REG_HDISP_END, 32'd752);
		reg_expect(REG_HSYNC_START, 32'd0);
		reg_expect(REG_HSYNC_END, 32'd96);
		reg_expect(REG_VTOTAL, 32'd525);
		reg_expect(REG_VDISP_START, 32'd12);
		reg_expect(REG_VDISP_END, 32'd492);
		reg_expect(REG_VSYNC_START, 32'd0);
		reg_expect(REG_VSYNC_END, 32'd2);
		reg_expect(REG_POLARITY, 32'd0);
		reg_expect(REG_PATTERN, 32'd0);
		reg_expect(REG_COLOR, 32'd0);
		// field masking
		reg_write(REG_HTOTAL, 32'habcd_e123);
		reg_expect(REG_HTOTAL, 32'h0000_0123);
		reg_write(REG_POLARITY, 32'hffff_ffff);
		reg_expect(REG_POLARITY, 32'd3);
		reg_write(REG_POLARITY, 32'd0);
		reg_write(REG_PATTERN, 32'hffff_ffff);
		reg_expect(REG_PATTERN, 32'd1);
		reg_write(REG_PATTERN, 32'd0);
		reg_write(REG_COLOR, 32'hff12_3456);
		reg_expect(REG_COLOR, 32'h0012_3456);
		reg_write(REG_COLOR, 32'd0);
		reg_write(REG_CTRL, 32'hffff_fffe);
		reg_expect(REG_CTRL, 32'd0);
		reg_write(REG_STATUS, 32'hffff_ffff);
		reg_expect(REG_STATUS, 32'd0);
		expect_slverr(1'b1, 8'h3c);
		expect_slverr(1'b0, 8'h40);
		expect_slverr(1'b0, 8'h06);
		expect_slverr(1'b1, 8'hfc);
	endtask

	// small random timing, sync pulses start at 0
	task automatic program_timing(input logic [1:0] pol);
		logic [31:0] r;
		logic [31:0] hse;
		logic [31:0] hds;
		logic [31:0] vt;
		logic [31:0] vse;
		logic [31:0] vds;
		draw_random(r);
		cur_ht = 32'd16 + r % 32'd9;
		draw_random(r);
		hse = 32'd2 + r % 32'd3;
		hds = hse + 32'd1 + (r >> 8) % 32'd3;
		draw_random(r);
		reg_write(REG_HTOTAL, cur_ht);
		reg_write(REG_HSYNC_START, 32'd0);
		reg_write(REG_HSYNC_END, hse);
		reg_write(REG_HDISP_START, hds);
		reg_write(REG_HDISP_END, hds + 32'd6 + r % (cur_ht - hds - 32'd6));
		draw_random(r);
		vt  = 32'd8 + r % 32'd5;
		vse = 32'd1 + (r >> 4) % 32'd2;
		vds = vse + (r >> 8) % 32'd2;
		draw_random(r);
		reg_write(REG_VTOTAL, vt);
		reg_write(REG_VSYNC_START, 32'd0);
		reg_write(REG_VSYNC_END, vse);
		reg_write(REG_VDISP_START, vds);
		reg_write(REG_VDISP_END, vds + 32'd3 + r % (vt - vds - 32'd2));
		hpol = pol[0];
		vpol = pol[1];
		reg_write(REG_POLARITY, {30'd0, pol});
	endtask

	task automatic run_video(input logic [1:0] pol, input logic restart);
		logic [31:0] r;
		logic [31:0] st;
		program_timing(pol);
		reg_write(REG_PATTERN, 32'd0);
		reg_write(REG_CTRL, 32'd1);
		wait_vsync(3);
		// solid colour over a full frame
		draw_random(r);
		reg_write(REG_COLOR, r & 32'h00ff_ffff);
		reg_write(REG_PATTERN, 32'd1);
		wait_vsync(2);
		reg_write(REG_PATTERN, 32'd0);
		// timing write in mid-frame
		wait_vsync(1);
		repeat (4) @(posedge peri_aclk);
		reg_write(REG_HTOTAL, cur_ht + 32'd1);
		wait_vsync(3);
		if (restart) begin
			reg_write(REG_CTRL, 32'd0);
			reg_read(REG_STATUS, st);
			check_value("busy in drain", 32'd1, {31'd0, st[0]});
			reg_write(REG_CTRL, 32'd1);
			wait_vsync(2);
		end
		wait_vsync(1);
		repeat (2) @(posedge peri_aclk);
		reg_write(REG_CTRL, 32'd0);
		reg_read(REG_STATUS, st);
		check_value("busy after disable", 32'd1, {31'd0, st[0]});
		wait_idle();
		reg_expect(REG_STATUS, 32'd0);
		check_quiet(100);
	endtask

	initial begin
		apb_req      = '0;
		peri_aresetn = 1'b0;
		rng          = 32'd56494;
		hpol         = 1'b0;
		vpol         = 1'b0;
		cur_ht       = 32'd0;
		repeat (4) @(posedge peri_aclk);
		#1;
		peri_aresetn = 1'b1;
		check_registers();
		for (int i = 0; i < 4; i++) begin
			run_video(2'(i), i == 2);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// File: video_out.f
verilog/vout_timing_pkg.sv
verilog/vout_bus_pkg.sv
verilog/vout_apb_regs.sv
verilog/vout_frame_fsm.sv
verilog/vout_timing_counter.sv
verilog/vout_pixel_gen.sv
verilog/vout_top.sv
sim/vout_assertions.sv
sim/vout_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f video_out.f \
	--top-module vout_tb \
	-o vout_sim

./obj_dir/vout_sim
